/* crc32_engine.sv */
// Gzip CRC-32 engine
// Watches the tracker bus, restarts on each data header and folds in
// eight payload bytes per transfer
`timescale 1ns/10ps
`default_nettype none

module crc32_engine import crc_tlv_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  tlv_if.mon   trk,
  output crc_t crc
);

  crc_t state;
  logic data_xfer;
  logic hdr_seen;

  // Reflected update, byte 0 first and bit 0 first within a byte
  function automatic crc_t fold_word(crc_t cur, tlv_word_t word);
    crc_t acc;
    acc = cur;
    for (int byte_i = 0; byte_i < 8; byte_i++) begin
      for (int bit_i = 0; bit_i < 8; bit_i++) begin
        if (acc[0] ^ word[8*byte_i+bit_i]) begin
          acc = (acc >> 1) ^ CRC_POLY;
        end else begin
          acc = acc >> 1;
        end
      end
    end
    return acc;
  endfunction

  assign data_xfer = trk.valid && trk.ready && (trk.typ == TLV_DATA);
  assign crc       = ~state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= CRC_INIT;
      hdr_seen <= 1'b0;
    end else if (data_xfer) begin
      if (trk.sot) begin
        state    <= CRC_INIT;   // Header word is not part of the CRC
        hdr_seen <= 1'b1;
      end else begin
        state <= fold_word(state, trk.data);
      end
    end
  end

  a_hdr_first: assert property (@(posedge clk) disable iff (!rst_n)
    data_xfer && !trk.sot |-> hdr_seen);

endmodule

`default_nettype wire

/* crc_tlv_pkg.sv */
// CRC TLV stage shared definitions
// Stream word and TLV type encodings, gzip CRC-32 constants, footer error code
`default_nettype none

package crc_tlv_pkg;

  typedef logic [63:0] tlv_word_t;   // One stream word
  typedef logic [31:0] crc_t;
  typedef logic [7:0]  word_num_t;   // Index of a word within its TLV
  typedef logic [7:0]  err_code_t;   // Footer last word, bits 7:0

  // TLV kinds handled by the stage, other codes pass through the tracker
  typedef enum logic [3:0] {
    TLV_CMD  = 4'h1,
    TLV_DATA = 4'h4,
    TLV_FTR  = 4'h8
  } tlv_type_e;

  // Per-frame CRC handling, from command word 1 bits 1:0
  typedef enum logic [1:0] {
    CRC_NONE = 2'd0,
    CRC_GEN  = 2'd1,
    CRC_CHK  = 2'd2
  } crc_mode_e;

  localparam word_num_t WORD_NUM_MAX  = 8'hff;   // Word index saturates here
  localparam word_num_t CMD_MODE_WORD = 8'd1;    // Command word holding the mode

  localparam crc_t CRC_POLY = 32'hedb88320;      // Reflected gzip polynomial
  localparam crc_t CRC_INIT = 32'hffffffff;

  localparam err_code_t CRC_ERR_CODE = 8'h2d;

endpackage

`default_nettype wire

/* crc_tlv_top.sv */
// CRC TLV stage top level
// Word tracker, gzip CRC-32 engine and footer checksum stage on plain ports
`timescale 1ns/10ps
`default_nettype none

module crc_tlv_top import crc_tlv_pkg::*; #(
  parameter word_num_t CKSUM_WORD_NUM = 8'd2
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      crc_gen_en,
  input  logic      crc_chk_en,
  input  logic      in_valid,
  output logic      in_ready,
  input  tlv_word_t in_data,
  input  tlv_type_e in_type,
  input  logic      in_sot,
  input  logic      in_eot,
  output logic      out_valid,
  input  logic      out_ready,
  output tlv_word_t out_data,
  output logic      out_sot,
  output logic      out_eot,
  output logic      crc_good,
  output logic      crc_err
);

  tlv_if     trk_bus ();
  crc_mode_e frame_mode;
  crc_t      crc;

  tlv_word_tracker u_tracker (
    .clk        (clk),
    .rst_n      (rst_n),
    .crc_gen_en (crc_gen_en),
    .crc_chk_en (crc_chk_en),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .in_type    (in_type),
    .in_sot     (in_sot),
    .in_eot     (in_eot),
    .trk        (trk_bus.src),
    .frame_mode (frame_mode)
  );

  crc32_engine u_crc (
    .clk   (clk),
    .rst_n (rst_n),
    .trk   (trk_bus.mon),
    .crc   (crc)
  );

  ftr_checksum_stage #(
    .CKSUM_WORD_NUM (CKSUM_WORD_NUM)
  ) u_ftr (
    .clk        (clk),
    .rst_n      (rst_n),
    .trk        (trk_bus.snk),
    .frame_mode (frame_mode),
    .crc        (crc),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .out_sot    (out_sot),
    .out_eot    (out_eot),
    .crc_good   (crc_good),
    .crc_err    (crc_err)
  );

endmodule

`default_nettype wire

/* ftr_checksum_stage.sv */
// Footer checksum stage
// Output register that keeps only footer words, inserts the CRC in
// generate mode or checks it and flags the footer error field
`timescale 1ns/10ps
`default_nettype none

module ftr_checksum_stage import crc_tlv_pkg::*; #(
  parameter word_num_t CKSUM_WORD_NUM = 8'd2
) (
  input  logic      clk,
  input  logic      rst_n,
  tlv_if.snk        trk,
  input  crc_mode_e frame_mode,
  input  crc_t      crc,
  output logic      out_valid,
  input  logic      out_ready,
  output tlv_word_t out_data,
  output logic      out_sot,
  output logic      out_eot,
  output logic      crc_good,
  output logic      crc_err
);

  logic      in_xfer;
  logic      is_ftr;
  logic      at_cksum;
  logic      do_chk;
  logic      cksum_match;
  logic      err_pend;
  err_code_t err_field;
  tlv_word_t ftr_word;

  assign trk.ready   = !out_valid || out_ready;
  assign in_xfer     = trk.valid && trk.ready;
  assign is_ftr      = (trk.typ == TLV_FTR);
  assign at_cksum    = is_ftr && (trk.word_num == CKSUM_WORD_NUM);
  assign do_chk      = in_xfer && at_cksum && (frame_mode == CRC_CHK);
  assign cksum_match = (trk.data[31:0] == crc);
  assign err_field   = trk.data[7:0];

  // Footer word as it leaves the stage
  always_comb begin
    ftr_word = trk.data;
    if (at_cksum && (frame_mode == CRC_GEN)) begin
      ftr_word = {32'd0, crc};
    end else if (is_ftr && trk.eot && err_pend && (err_field == '0)) begin
      ftr_word[7:0] = CRC_ERR_CODE;   // Keep an earlier error
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      crc_good  <= 1'b0;
      crc_err   <= 1'b0;
      err_pend  <= 1'b0;
    end else begin
      if (trk.ready) begin
        out_valid <= trk.valid && is_ftr;   // Other TLVs are absorbed
      end
      crc_good <= do_chk && cksum_match;
      crc_err  <= do_chk && !cksum_match;
      if (do_chk) begin
        err_pend <= !cksum_match;
      end else if (in_xfer && is_ftr && trk.eot) begin
        err_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer && is_ftr) begin
      out_data <= ftr_word;
      out_sot  <= trk.sot;
      out_eot  <= trk.eot;
    end
  end

  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

  a_one_event: assert property (@(posedge clk) disable iff (!rst_n)
    (crc_good || crc_err) |=> !(crc_good || crc_err));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CRC TLV testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f tb.f --top-module tb_crc_tlv -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/sim_tb 2>&1)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -Fqx "Simulation PASSED"; then
  exit 0
fi
echo "Pass message not found"
exit 1

/* tb.f */
crc_tlv_pkg.sv
tlv_if.sv
tlv_word_tracker.sv
crc32_engine.sv
ftr_checksum_stage.sv
crc_tlv_top.sv
tb_crc_tlv.sv

/* tb_crc_tlv.sv */
// Testbench for the CRC TLV stage
// Random frames in generate, check and pass-through modes, compared
// against a reference gzip CRC-32 and expected footer queues
`timescale 1ns/10ps
`default_nettype none

module tb_crc_tlv import crc_tlv_pkg::*; ();

  localparam int CLK_PERIOD      = 100;
  localparam int DRIVE_DLY       = 1;
  localparam int RST_CYCLES      = 4;
  localparam int NUM_FRAMES      = 48;
  localparam int MAX_FRAME_WORDS = 15;   // Command 2, data 1+8, footer 4
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * MAX_FRAME_WORDS * 20;
  localparam int DRAIN_CYCLES    = 20;
  localparam logic [31:0] SEED   = 32'd17394;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      crc_gen_en;
  logic      crc_chk_en;
  logic      in_valid;
  logic      in_ready;
  tlv_word_t in_data;
  tlv_type_e in_type;
  logic      in_sot;
  logic      in_eot;
  logic      out_valid;
  logic      out_ready;
  tlv_word_t out_data;
  logic      out_sot;
  logic      out_eot;
  logic      crc_good;
  logic      crc_err;

  logic [31:0] stim_rng = SEED;
  logic [31:0] bp_rng   = SEED ^ 32'h9e3779b9;

  tlv_word_t  exp_data [$];
  logic [1:0] exp_frm [$];     // {sot, eot}
  string      exp_tag [$];
  logic [1:0] exp_pulse [$];   // 01 good, 10 error
  string      pulse_tag [$];

  string      mon_tag;
  tlv_word_t  mon_data;
  logic [1:0] mon_bits;

  // Occupancy of the two register stages
  logic trk_busy;
  logic trk_is_ftr;
  logic out_busy;
  logic exp_ftr_ready;
  logic exp_in_ready;

  crc_tlv_top #(
    .CKSUM_WORD_NUM (8'd2)
  ) u_crc_tlv_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .crc_gen_en (crc_gen_en),
    .crc_chk_en (crc_chk_en),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .in_type    (in_type),
    .in_sot     (in_sot),
    .in_eot     (in_eot),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .out_sot    (out_sot),
    .out_eot    (out_eot),
    .crc_good   (crc_good),
    .crc_err    (crc_err)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_stim();
    stim_rng = xorshift32(stim_rng);
    return stim_rng;
  endfunction

  function automatic tlv_word_t rand64();
    return {next_stim(), next_stim()};
  endfunction

  // Byte-wise reflected CRC-32 with the low byte of each word first
  function automatic crc_t gzip_crc32(input tlv_word_t words [8], input int count);
    logic [31:0] c;
    c = 32'hffffffff;
    for (int w = 0; w < count; w++) begin
      for (int i = 0; i < 8; i++) begin
        c = c ^ {24'd0, words[w][8*i +: 8]};
        for (int k = 0; k < 8; k++) begin
          c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
        end
      end
    end
    return ~c;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      fail_run("Output differs from the expected value");
    end
  endtask

  // Entered and left a drive delay after a clock edge
  task automatic send_word(input tlv_word_t data, input tlv_type_e typ,
                           input logic sot, input logic eot);
    logic [31:0] r;
    r = next_stim();
    if (r[1:0] == 2'd0) begin
      in_valid = 1'b0;   // Idle gap
      repeat (int'(r[3:2]) + 1) begin
        @(posedge clk);
        #DRIVE_DLY;
      end
    end
    in_valid = 1'b1;
    in_data  = data;
    in_type  = typ;
    in_sot   = sot;
    in_eot   = eot;
    @(posedge clk);
    while (!in_ready) @(posedge clk);
    #DRIVE_DLY;
    in_valid = 1'b0;
  endtask

  task automatic send_frame(input int f);
    tlv_word_t   payload [8];
    tlv_word_t   ftr [4];
    tlv_word_t   exp_ftr [4];
    tlv_word_t   cmd_word;
    int          n_payload;
    logic [31:0] r;
    logic [1:0]  mode_code;
    logic        gen_en;
    logic        chk_en;
    logic        bad;
    logic        zero_field;
    crc_mode_e   eff_mode;
    crc_t        ref_crc;
    r          = next_stim();
    n_payload  = int'(r[2:0]) + 1;
    mode_code  = r[5:4];
    gen_en     = (r[10:8] != 3'd0);
    chk_en     = (r[14:12] != 3'd0);
    bad        = r[16];
    zero_field = r[17];
    if (f < 7) begin
      gen_en = 1'b1;
      chk_en = 1'b1;
    end
    case (f)   // Directed frames ahead of the random ones
      0: mode_code = 2'd1;
      1: begin
        mode_code = 2'd2;
        bad       = 1'b0;
      end
      2: begin
        mode_code  = 2'd2;
        bad        = 1'b1;
        zero_field = 1'b1;
      end
      3: begin
        mode_code  = 2'd2;
        bad        = 1'b1;
        zero_field = 1'b0;
      end
      4: mode_code = 2'd0;
      5: begin
        mode_code = 2'd1;
        gen_en    = 1'b0;
      end
      6: begin
        mode_code = 2'd2;
        chk_en    = 1'b0;
        bad       = 1'b1;
      end
      default: ;
    endcase
    if (mode_code == 2'd1 && gen_en) eff_mode = CRC_GEN;
    else if (mode_code == 2'd2 && chk_en) eff_mode = CRC_CHK;
    else eff_mode = CRC_NONE;

    for (int i = 0; i < 8; i++) payload[i] = rand64();
    ref_crc = gzip_crc32(payload, n_payload);
    for (int i = 0; i < 4; i++) ftr[i] = rand64();
    r = next_stim();
    ftr[3][7:0] = zero_field ? 8'h00 : (r[7:0] | 8'h01);
    ftr[2][31:0] = ref_crc;
    if (bad) ftr[2][31:0] = ref_crc ^ (next_stim() | 32'd1);

    exp_ftr = ftr;
    if (eff_mode == CRC_GEN) exp_ftr[2] = {32'd0, ref_crc};
    if (eff_mode == CRC_CHK) begin
      if (bad && zero_field) exp_ftr[3][7:0] = CRC_ERR_CODE;
      exp_pulse.push_back(bad ? 2'b10 : 2'b01);
      pulse_tag.push_back($sformatf("frame %0d check event", f));
    end
    for (int i = 0; i < 4; i++) begin
      exp_data.push_back(exp_ftr[i]);
      exp_frm.push_back({i == 0, i == 3});
      exp_tag.push_back($sformatf("frame %0d %s footer word %0d", f, eff_mode.name(), i));
    end

    cmd_word      = rand64();
    cmd_word[1:0] = mode_code;
    crc_gen_en    = gen_en;
    crc_chk_en    = chk_en;
    send_word(rand64(), TLV_CMD, 1'b1, 1'b0);
    send_word(cmd_word, TLV_CMD, 1'b0, 1'b1);
    send_word(rand64(), TLV_DATA, 1'b1, 1'b0);
    for (int i = 0; i < n_payload; i++) begin
      send_word(payload[i], TLV_DATA, 1'b0, i == n_payload - 1);
    end
    for (int i = 0; i < 4; i++) begin
      send_word(ftr[i], TLV_FTR, i == 0, i == 3);
    end
  endtask

  // Random back-pressure on the output side
  always @(posedge clk) begin
    #DRIVE_DLY;
    bp_rng    = xorshift32(bp_rng);
    out_ready = (bp_rng[1:0] != 2'b00);
  end

  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      if (exp_data.size() == 0) begin
        fail_run("A footer word left the DUT when none was expected");
      end else begin
        mon_tag  = exp_tag.pop_front();
        mon_data = exp_data.pop_front();
        mon_bits = exp_frm.pop_front();
        check_value(mon_tag, mon_data, out_data);
        check_value({mon_tag, " sot/eot"}, {62'd0, mon_bits}, {62'd0, out_sot, out_eot});
      end
    end
    if (rst_n && (crc_good || crc_err)) begin
      if (exp_pulse.size() == 0) begin
        fail_run("A CRC event pulse occurred when none was expected");
      end else begin
        mon_tag  = pulse_tag.pop_front();
        mon_bits = exp_pulse.pop_front();
        check_value(mon_tag, {62'd0, mon_bits}, {62'd0, crc_err, crc_good});
      end
    end
  end

  // Input ready and output valid follow the two-stage occupancy
  always @(posedge clk) begin
    if (!rst_n) begin
      trk_busy = 1'b0;
      out_busy = 1'b0;
    end else begin
      exp_ftr_ready = !out_busy || out_ready;
      exp_in_ready  = !trk_busy || exp_ftr_ready;
      check_value("in_ready", {63'd0, exp_in_ready}, {63'd0, in_ready});
      check_value("out_valid", {63'd0, out_busy}, {63'd0, out_valid});
      if (exp_ftr_ready) begin
        out_busy = trk_busy && trk_is_ftr;
      end
      if (exp_in_ready) begin
        trk_busy   = in_valid;
        trk_is_ftr = (in_type == TLV_FTR);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run("Timeout: the DUT did not deliver all expected footers in time");
  end

  initial begin
    rst_n      = 1'b0;
    crc_gen_en = 1'b1;
    crc_chk_en = 1'b1;
    in_valid   = 1'b0;
    in_data    = '0;
    in_type    = TLV_CMD;
    in_sot     = 1'b0;
    in_eot     = 1'b0;
    out_ready  = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    @(posedge clk);
    check_value("out_valid after reset", 64'd0, {63'd0, out_valid});
    check_value("crc_good after reset", 64'd0, {63'd0, crc_good});
    check_value("crc_err after reset", 64'd0, {63'd0, crc_err});
    #DRIVE_DLY;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      send_frame(f);
    end
    while (exp_data.size() != 0 || exp_pulse.size() != 0) @(posedge clk);
    repeat (DRAIN_CYCLES) @(posedge clk);   // Catch late extra words or pulses
    if (exp_data.size() == 0 && exp_pulse.size() == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      fail_run("Expected footer words or events were left over");
    end
  end

endmodule

`default_nettype wire

/* tlv_if.sv */
// TLV word bus between the tracker and the footer stage
// One word per transfer with valid/ready, TLV type, framing and word index
`timescale 1ns/10ps
`default_nettype none

interface tlv_if import crc_tlv_pkg::*; ();

  logic      valid;
  logic      ready;
  tlv_word_t data;
  tlv_type_e typ;
  logic      sot;
  logic      eot;
  word_num_t word_num;

  modport src (output valid, data, typ, sot, eot, word_num, input ready);
  modport snk (input valid, data, typ, sot, eot, word_num, output ready);
  modport mon (input valid, ready, data, typ, sot, eot, word_num);

endinterface

`default_nettype wire

/* tlv_word_tracker.sv */
// TLV word tracker
// Input register stage, tags each word with its index inside the TLV
// and latches the frame CRC mode from command word 1
`timescale 1ns/10ps
`default_nettype none

module tlv_word_tracker import crc_tlv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      crc_gen_en,
  input  logic      crc_chk_en,
  input  logic      in_valid,
  output logic      in_ready,
  input  tlv_word_t in_data,
  input  tlv_type_e in_type,
  input  logic      in_sot,
  input  logic      in_eot,
  tlv_if.src        trk,
  output crc_mode_e frame_mode
);

  word_num_t next_num;
  crc_mode_e req_mode;
  logic      in_xfer;

  assign in_ready = !trk.valid || trk.ready;   // Empty or draining
  assign in_xfer  = in_valid && in_ready;

  // Index of the incoming word, from the last accepted one
  always_comb begin
    if (in_sot) begin
      next_num = '0;
    end else if (trk.word_num == WORD_NUM_MAX) begin
      next_num = WORD_NUM_MAX;
    end else begin
      next_num = trk.word_num + 8'd1;
    end
  end

  always_comb begin
    case (in_data[1:0])
      CRC_GEN: req_mode = crc_gen_en ? CRC_GEN : CRC_NONE;
      CRC_CHK: req_mode = crc_chk_en ? CRC_CHK : CRC_NONE;
      default: req_mode = CRC_NONE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trk.valid    <= 1'b0;
      trk.word_num <= '0;
      frame_mode   <= CRC_NONE;
    end else begin
      if (in_ready) begin
        trk.valid <= in_valid;
      end
      if (in_xfer) begin
        trk.word_num <= next_num;
      end
      if (in_xfer && (in_type == TLV_CMD) && (next_num == CMD_MODE_WORD)) begin
        frame_mode <= req_mode;   // Held until the next command
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      trk.data <= in_data;
      trk.typ  <= in_type;
      trk.sot  <= in_sot;
      trk.eot  <= in_eot;
    end
  end

  a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    trk.valid && !trk.ready |=> trk.valid && $stable(trk.data) && $stable(trk.word_num));

endmodule

`default_nettype wire
